//--- design/fetch_fifo.sv
// Instruction word FIFO
// Circular buffer with flush, fill count and full/empty flags
// Head word is shown combinationally for the fetch output mux

`default_nettype none

`include "prefetch_consts.svh"

module fetch_fifo (
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            flush_i,   // Wins over push in the same cycle
  input  logic            push_i,
  input  logic            pop_i,
  input  obi_pkg::data_t  data_i,
  output obi_pkg::data_t  data_o,
  output fetch_pkg::cnt_t cnt_o,
  output logic            empty_o,
  output logic            full_o
);

  localparam int unsigned PTR_W = `FETCH_CNT_W - 1;
  localparam logic [PTR_W-1:0] LAST = PTR_W'(`FETCH_DEPTH - 1);

  obi_pkg::data_t  mem [`FETCH_DEPTH];
  logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
  fetch_pkg::cnt_t  cnt_q;
  logic            do_push, do_pop;

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == fetch_pkg::cnt_t'(`FETCH_DEPTH));
  assign cnt_o   = cnt_q;
  assign data_o  = mem[rd_ptr_q];  // Head word

  // Guard against over/underflow, push into full only with a pop
  assign do_pop  = pop_i && !empty_o;
  assign do_push = push_i && (!full_o || do_pop);

  // Pointers and count
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_pop) rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
      if (do_push) wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
      if (do_push && !do_pop) cnt_q <= cnt_q + 1'b1;
      else if (do_pop && !do_push) cnt_q <= cnt_q - 1'b1;
    end
  end

  // Storage, no reset needed
  always_ff @(posedge clk) begin
    if (do_push && !flush_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- design/fetch_pkg.sv
// Fetch side types
// Occupancy and outstanding counters plus the controller FSM states

`default_nettype none

`include "prefetch_consts.svh"

package fetch_pkg;

  // Shared by FIFO fill level, in-flight requests and discard credits
  typedef logic [`FETCH_CNT_W-1:0] cnt_t;

  // Controller FSM
  // IDLE until the first branch gives a start address
  typedef enum logic {
    IDLE     = 1'b0,
    FETCHING = 1'b1   // Address valid, requests may go out
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- design/obi_interface.sv
// OBI request channel for instruction fetch
// Registers one request and holds req and addr stable until the grant
// Read responses are handed straight back with no added latency

`default_nettype none

module obi_interface (
  input  logic            clk,
  input  logic            arst_n_i,

  // Transaction side, from the prefetch controller
  input  logic            trans_valid_i,
  input  obi_pkg::addr_t  trans_addr_i,
  output logic            trans_ready_o,

  // Response side
  output logic            resp_valid_o,
  output obi_pkg::data_t  resp_rdata_o,

  // Bus side
  output logic            obi_req_o,
  output obi_pkg::addr_t  obi_addr_o,
  input  logic            obi_gnt_i,
  input  logic            obi_rvalid_i,
  input  obi_pkg::data_t  obi_rdata_i
);

  logic           req_q;   // Request waiting for grant
  obi_pkg::addr_t addr_q;  // Held address of that request
  logic           accept;  // New transaction taken this cycle

  //////////////////////////////////////////////////
  // Request register
  //////////////////////////////////////////////////

  // Free when nothing is waiting, or the waiting one is granted now
  assign trans_ready_o = !req_q || obi_gnt_i;
  assign accept        = trans_valid_i && trans_ready_o;

  // Waiting flag, the only control state here
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_q <= 1'b0;
    end else if (trans_ready_o) begin
      req_q <= trans_valid_i;  // Drop after grant unless a new one follows
    end
  end

  // Address payload only changes at a handshake boundary
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= trans_addr_i;
    end
  end

  assign obi_req_o  = req_q;
  assign obi_addr_o = addr_q;

  //////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////

  // In-order responses, zero cycle pass-through
  assign resp_valid_o = obi_rvalid_i;
  assign resp_rdata_o = obi_rdata_i;

endmodule

`default_nettype wire

//--- design/obi_pkg.sv
// Instruction bus types
// Byte address and returned data word of the OBI-style port

`default_nettype none

`include "prefetch_consts.svh"

package obi_pkg;

  // Byte address, fetches always word aligned
  typedef logic [`BUS_AW-1:0] addr_t;

  typedef logic [`BUS_DW-1:0] data_t;  // Raw instruction word

endpackage

`default_nettype wire

//--- design/prefetch_buffer.sv
// Instruction prefetch buffer, top level
// Bus request channel, word FIFO and prefetch controller
// plus the fall-through select for the fetch data output

`default_nettype none

`include "prefetch_consts.svh"

module prefetch_buffer (
  input  logic           clk,
  input  logic           arst_n_i,

  // Core side
  input  logic           req_i,
  input  logic           branch_i,
  input  obi_pkg::addr_t branch_addr_i,
  input  logic           fetch_ready_i,
  output logic           fetch_valid_o,
  output obi_pkg::data_t fetch_rdata_o,
  output logic           busy_o,

  // Instruction memory side
  output logic           instr_req_o,
  output obi_pkg::addr_t instr_addr_o,
  input  logic           instr_gnt_i,
  input  obi_pkg::data_t instr_rdata_i,
  input  logic           instr_rvalid_i
);

  // Controller <-> bus interface
  logic            trans_valid, trans_ready;
  obi_pkg::addr_t  trans_addr;

  logic            resp_valid;
  obi_pkg::data_t  resp_rdata;

  // FIFO control and status
  logic            fifo_push, fifo_pop, fifo_flush;
  fetch_pkg::cnt_t fifo_cnt;
  logic            fifo_empty;
  obi_pkg::data_t  fifo_rdata;

  //////////////////////////////////////////////////
  // Bus request channel
  //////////////////////////////////////////////////

  obi_interface instruction_obi (
    .clk           ( clk            ),
    .arst_n_i      ( arst_n_i       ),
    .trans_valid_i ( trans_valid    ),
    .trans_addr_i  ( trans_addr     ),
    .trans_ready_o ( trans_ready    ),
    .resp_valid_o  ( resp_valid     ),
    .resp_rdata_o  ( resp_rdata     ),
    .obi_req_o     ( instr_req_o    ),
    .obi_addr_o    ( instr_addr_o   ),
    .obi_gnt_i     ( instr_gnt_i    ),
    .obi_rvalid_i  ( instr_rvalid_i ),
    .obi_rdata_i   ( instr_rdata_i  )
  );

  //////////////////////////////////////////////////
  // Word FIFO and fall-through
  //////////////////////////////////////////////////

  fetch_fifo instr_fifo (
    .clk      ( clk        ),
    .arst_n_i ( arst_n_i   ),
    .flush_i  ( fifo_flush ),
    .push_i   ( fifo_push  ),
    .pop_i    ( fifo_pop   ),
    .data_i   ( resp_rdata ),
    .data_o   ( fifo_rdata ),
    .cnt_o    ( fifo_cnt   ),
    .empty_o  ( fifo_empty ),
    .full_o   (            )   // Room is checked from the count
  );

  // Head first, else the live response, zero when nothing arrives
  assign fetch_rdata_o = fifo_empty ? (resp_rdata & {`BUS_DW{resp_valid}}) : fifo_rdata;

  prefetch_controller prefetch_ctrl (
    .clk           ( clk           ),
    .arst_n_i      ( arst_n_i      ),
    .req_i         ( req_i         ),
    .branch_i      ( branch_i      ),
    .branch_addr_i ( branch_addr_i ),
    .trans_valid_o ( trans_valid   ),
    .trans_addr_o  ( trans_addr    ),
    .trans_ready_i ( trans_ready   ),
    .resp_valid_i  ( resp_valid    ),
    .fetch_ready_i ( fetch_ready_i ),
    .fetch_valid_o ( fetch_valid_o ),
    .fifo_push_o   ( fifo_push     ),
    .fifo_pop_o    ( fifo_pop      ),
    .fifo_flush_o  ( fifo_flush    ),
    .fifo_cnt_i    ( fifo_cnt      ),
    .fifo_empty_i  ( fifo_empty    ),
    .busy_o        ( busy_o        )
  );

endmodule

`default_nettype wire

//--- design/prefetch_consts.svh
// Prefetch buffer constants
// FIFO depth doubles as the limit on outstanding bus requests
// Bus widths match a 32-bit RISC-V instruction port

`ifndef PREFETCH_CONSTS_SVH
`define PREFETCH_CONSTS_SVH

// Words of buffering and max requests in flight, must be >= 2
`define FETCH_DEPTH 2

// Count from 0 up to FETCH_DEPTH inclusive
`define FETCH_CNT_W ($clog2(`FETCH_DEPTH) + 1)

// Instruction bus widths
`define BUS_AW 32
`define BUS_DW 32

`endif

//--- design/prefetch_controller.sv
// Prefetch controller
// Generates sequential word addresses from the last branch target,
// limits in-flight plus buffered words to the FIFO depth,
// discards responses that belong to fetches before a branch,
// and drives the FIFO push/pop/flush and the fetch valid

`default_nettype none

`include "prefetch_consts.svh"

module prefetch_controller (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   req_i,
  input  logic                   branch_i,
  input  obi_pkg::addr_t         branch_addr_i,

  // Transaction request towards the bus interface
  output logic                   trans_valid_o,
  output obi_pkg::addr_t         trans_addr_o,
  input  logic                   trans_ready_i,

  input  logic                   resp_valid_i,

  // Core fetch handshake
  input  logic                   fetch_ready_i,
  output logic                   fetch_valid_o,

  // FIFO control
  output logic                   fifo_push_o,
  output logic                   fifo_pop_o,
  output logic                   fifo_flush_o,
  input  fetch_pkg::cnt_t        fifo_cnt_i,
  input  logic                   fifo_empty_i,

  output logic                   busy_o
);

  fetch_pkg::ctrl_state_e state_q, state_d;
  obi_pkg::addr_t         next_addr_q, next_addr_d;  // Next word to request
  fetch_pkg::cnt_t        outstanding_q, outstanding_d;  // Accepted, not yet answered
  fetch_pkg::cnt_t        discard_q, discard_d;  // Stale responses still to drop

  logic trans_accept;
  logic resp_drop;   // Response from before the last branch
  logic resp_keep;   // Response for the current stream

  //////////////////////////////////////////////////
  // Request issue
  //////////////////////////////////////////////////

  // Room check counts stale in-flight words too, which is conservative
  assign trans_valid_o = (state_q == fetch_pkg::FETCHING) && req_i && !branch_i &&
                         ((outstanding_q + fifo_cnt_i) < `FETCH_DEPTH);
  assign trans_addr_o  = next_addr_q;
  assign trans_accept  = trans_valid_o && trans_ready_i;

  //////////////////////////////////////////////////
  // Response handling and fetch side
  //////////////////////////////////////////////////

  assign resp_drop = resp_valid_i && (branch_i || (discard_q != '0));
  assign resp_keep = resp_valid_i && !resp_drop;

  // Valid from FIFO head, or a live response falling through
  assign fetch_valid_o = !branch_i && (!fifo_empty_i || resp_keep);

  assign fifo_flush_o = branch_i;
  assign fifo_pop_o   = fetch_valid_o && fetch_ready_i && !fifo_empty_i;
  // Skip the FIFO when it is empty and the core takes the word now
  assign fifo_push_o  = resp_keep && !(fifo_empty_i && fetch_ready_i);

  assign busy_o = (outstanding_q != '0);  // Includes a request waiting for grant

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    next_addr_d   = next_addr_q;
    outstanding_d = outstanding_q;
    discard_d     = discard_q;

    // In-flight bookkeeping
    if (trans_accept) outstanding_d = outstanding_d + 1'b1;
    if (resp_valid_i) outstanding_d = outstanding_d - 1'b1;

    if (branch_i) begin
      state_d     = fetch_pkg::FETCHING;
      next_addr_d = {branch_addr_i[`BUS_AW-1:2], 2'b00};  // Word aligned target
      // Everything still in flight is now stale
      discard_d   = outstanding_q;
      if (resp_valid_i) discard_d = discard_d - 1'b1;
    end else begin
      if (trans_accept) next_addr_d = next_addr_q + 'd4;
      if (resp_drop) discard_d = discard_q - 1'b1;  // Use up one credit
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= fetch_pkg::IDLE;
      next_addr_q   <= '0;
      outstanding_q <= '0;
      discard_q     <= '0;
    end else begin
      state_q       <= state_d;
      next_addr_q   <= next_addr_d;
      outstanding_q <= outstanding_d;
      discard_q     <= discard_d;
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the prefetch buffer testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module prefetch_buffer_tb -Mdir obj_dir -f src.f

./obj_dir/Vprefetch_buffer_tb | tee sim.log

if grep -qF '*** FAILED ***' sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

if ! grep -qF '*** PASSED ***' sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

//--- src.f
+incdir+design
design/obi_pkg.sv
design/fetch_pkg.sv
design/obi_interface.sv
design/fetch_fifo.sv
design/prefetch_controller.sv
design/prefetch_buffer.sv
tests/prefetch_buffer_properties.sv
tests/prefetch_buffer_tb.sv

//--- tests/prefetch_buffer_properties.sv
// Bus protocol checks for the prefetch buffer
// Request hold until grant and the limit on requests in flight

`default_nettype none

`include "prefetch_consts.svh"

module prefetch_buffer_properties (
  input logic           clk,
  input logic           arst_n_i,
  input logic           instr_req_o,
  input logic           instr_gnt_i,
  input logic           instr_rvalid_i,
  input obi_pkg::addr_t instr_addr_o
);

  int in_flight;  // Granted minus answered, seen at the ports

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(instr_req_o && instr_gnt_i) - int'(instr_rvalid_i);
    end
  end

  // Waiting request keeps req and address
  hold_until_gnt: assert property (@(posedge clk) disable iff (!arst_n_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("request dropped or address changed before grant");

  max_in_flight: assert property (@(posedge clk) disable iff (!arst_n_i)
    in_flight <= `FETCH_DEPTH)
    else $error("more than FETCH_DEPTH requests in flight");

endmodule

bind prefetch_buffer prefetch_buffer_properties props0 (
  .clk            ( clk            ),
  .arst_n_i       ( arst_n_i       ),
  .instr_req_o    ( instr_req_o    ),
  .instr_gnt_i    ( instr_gnt_i    ),
  .instr_rvalid_i ( instr_rvalid_i ),
  .instr_addr_o   ( instr_addr_o   )
);

`default_nettype wire

//--- tests/prefetch_buffer_tb.sv
// Prefetch buffer testbench
// LFSR driven grants, response delays, fetch stalls and branches
// Memory model answers in order with the inverted word address,
// fetched words are checked against the expected sequential stream

`default_nettype none

module prefetch_buffer_tb;

  localparam int PERIOD       = 40;
  localparam int IDLE_CYCLES  = 10;
  localparam int WORDS        = 200;  // Accepted words per streaming test
  localparam int DRAIN_CYCLES = 20;
  localparam int TEST_CYCLES  = IDLE_CYCLES + 3 * WORDS + DRAIN_CYCLES;

  logic           clk = 1'b0;
  logic           arst_n_i, req_i, branch_i, fetch_ready_i;
  obi_pkg::addr_t branch_addr_i;
  logic           fetch_valid_o, busy_o;
  obi_pkg::data_t fetch_rdata_o;
  logic           instr_req_o, instr_gnt_i, instr_rvalid_i;
  obi_pkg::addr_t instr_addr_o;
  obi_pkg::data_t instr_rdata_i;

  // Stimulus control, set by the sequence at the falling edge
  logic           req_en = 1'b0;
  logic           ready_rand = 1'b0;  // Random fetch stalls
  logic           branch_rand = 1'b0;  // Random branch pulses
  logic           branch_cmd = 1'b0;  // One branch requested by the sequence
  obi_pkg::addr_t branch_cmd_addr = '0;

  logic [15:0]    lfsr = 16'd23629;
  obi_pkg::addr_t exp_req_addr = '0;  // Next address of the live stream
  obi_pkg::addr_t exp_fetch_addr = '0;
  obi_pkg::addr_t stale_addr = '0;
  logic           stale_req = 1'b0;  // Request still waiting for grant across a branch
  obi_pkg::addr_t rsp_addr_q[$];  // Granted, not yet answered
  int             rsp_due_q[$];
  int             cyc = 0, words = 0, checks = 0, errors = 0;
  int             tests_run = 0, tests_failed = 0;

  prefetch_buffer dut0 (
    .clk            ( clk            ),
    .arst_n_i       ( arst_n_i       ),
    .req_i          ( req_i          ),
    .branch_i       ( branch_i       ),
    .branch_addr_i  ( branch_addr_i  ),
    .fetch_ready_i  ( fetch_ready_i  ),
    .fetch_valid_o  ( fetch_valid_o  ),
    .fetch_rdata_o  ( fetch_rdata_o  ),
    .busy_o         ( busy_o         ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .instr_rvalid_i ( instr_rvalid_i )
  );

  always #(PERIOD / 2) clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);  // One step per bit
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check_data(input string name, input obi_pkg::data_t got,
                            input obi_pkg::data_t exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t: %s got %08h expected %08h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input obi_pkg::addr_t got,
                            input obi_pkg::addr_t exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t: %s got %08h expected %08h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int e0);
    tests_run++;
    if (errors != e0) tests_failed++;
    $display("Test %s: %s, %0d errors", name, (errors == e0) ? "ok" : "failing", errors - e0);
  endtask

  //////////////////////////////////////////////////
  // Cycle engine: models, memory responder, drives
  //////////////////////////////////////////////////

  always @(posedge clk) begin : cycle_engine
    logic [31:0]    r;
    obi_pkg::addr_t a;
    if (arst_n_i) begin
      if (fetch_valid_o && fetch_ready_i) begin  // Word accepted by the core
        check_data("fetch_rdata_o", fetch_rdata_o, ~exp_fetch_addr);
        exp_fetch_addr = exp_fetch_addr + 32'd4;
        words++;
      end
      if (instr_req_o && instr_gnt_i) begin
        if (stale_req) begin
          check_addr("instr_addr_o", instr_addr_o, stale_addr);
          stale_req = 1'b0;
        end else begin
          check_addr("instr_addr_o", instr_addr_o, exp_req_addr);
          exp_req_addr = exp_req_addr + 32'd4;
        end
        take_bits(2, r);
        rsp_addr_q.push_back(instr_addr_o);
        rsp_due_q.push_back(cyc + int'(r[1:0] % 2'd3));  // 1 to 3 cycles
      end
      if (branch_i) begin
        if (instr_req_o && !instr_gnt_i && !stale_req) begin
          stale_req  = 1'b1;
          stale_addr = exp_req_addr;
        end
        exp_req_addr   = {branch_addr_i[31:2], 2'b00};
        exp_fetch_addr = exp_req_addr;
      end
      // In order answers
      if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cyc) begin
        a = rsp_addr_q.pop_front();
        void'(rsp_due_q.pop_front());
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= ~a;
      end else begin
        instr_rvalid_i <= 1'b0;
        instr_rdata_i  <= '0;
      end
      take_bits(1, r);
      instr_gnt_i <= r[0];
      if (ready_rand) begin
        take_bits(2, r);
        fetch_ready_i <= (r[1:0] != 2'b00);  // Stall one cycle in four
      end else begin
        fetch_ready_i <= 1'b1;
      end
      branch_i <= 1'b0;
      if (branch_cmd) begin
        branch_i      <= 1'b1;
        branch_addr_i <= branch_cmd_addr;
        branch_cmd     = 1'b0;
      end else if (branch_rand) begin
        take_bits(5, r);
        if (r[4:0] == 5'd0) begin
          take_bits(16, r);
          branch_i      <= 1'b1;
          branch_addr_i <= {16'h0, r[15:0]};  // Often unaligned
        end
      end
      req_i <= req_en;
      cyc++;
    end
  end

  task automatic run_stream(input string name, input obi_pkg::addr_t target);
    int e0;
    int w0;
    e0              = errors;
    branch_cmd_addr = target;
    branch_cmd      = 1'b1;
    while (branch_cmd) @(negedge clk);
    w0 = words;
    while (words < w0 + WORDS) @(negedge clk);
    report_test(name, e0);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int e0;
    arst_n_i       = 1'b0;
    req_i          = 1'b0;
    branch_i       = 1'b0;
    branch_addr_i  = '0;
    fetch_ready_i  = 1'b1;
    instr_gnt_i    = 1'b0;
    instr_rdata_i  = '0;
    instr_rvalid_i = 1'b0;
    repeat (2) @(posedge clk);
    arst_n_i <= 1'b1;
    @(negedge clk);

    // Requests enabled but no start address yet
    e0     = errors;
    req_en = 1'b1;
    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      if (instr_req_o || fetch_valid_o || busy_o) begin
        $display("Error at %0t: bus or fetch activity before the first branch", $time);
        errors++;
      end
    end
    report_test("reset_idle", e0);

    run_stream("sequential", 32'h0000_1002);
    ready_rand = 1'b1;
    run_stream("backpressure", 32'h0000_4000);
    branch_rand = 1'b1;
    run_stream("random_branches", 32'h0000_8001);
    branch_rand = 1'b0;

    // Drain with requests off
    e0         = errors;
    req_en     = 1'b0;
    ready_rand = 1'b0;
    repeat (2) @(negedge clk);  // Let req_i drop first
    while (busy_o) @(negedge clk);
    if (rsp_addr_q.size() != 0) begin
      $display("Error at %0t: busy_o fell with responses still due", $time);
      errors++;
    end
    repeat (DRAIN_CYCLES) begin
      @(negedge clk);
      if (busy_o || instr_req_o) begin
        $display("Error at %0t: bus activity after the drain", $time);
        errors++;
      end
    end
    report_test("drain", e0);

    $display("Tests %0d, failing %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog, eight periods per planned test cycle
  initial begin
    #(TEST_CYCLES * 8 * PERIOD);
    $display("Timeout: run did not end within %0d cycles", TEST_CYCLES * 8);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
